// ==== verilog/spi_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the spi subsystem
// owner tag and engine state enums, request and response structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_pkg;

	// which client a transfer belongs to
	typedef enum logic {
		OWN_HOST = 1'b0,				// host command port
		OWN_POLL = 1'b1					// status poller
	} spi_owner_e;

	// engine states
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,					// cs high, waiting for start
		ST_HALF = 3'd1,					// counting out a half period
		ST_EDGE = 3'd2,					// sclk toggles at end of this cycle
		ST_LAST = 3'd3,					// trailing half period before cs rises
		ST_DONE = 3'd4					// done strobe cycle
	} spi_state_e;

	// request into the engine
	typedef struct packed {
		spi_owner_e owner;				// tag carried through to response
		logic [7:0] data;				// byte for mosi
	} spi_xfer_t;

	// completed transfer out of the engine
	typedef struct packed {
		spi_owner_e owner;				// copied from request
		logic [7:0] data;				// byte from miso
	} spi_rsp_t;

endpackage

// ==== verilog/spi_master.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi_master: one-byte spi engine, single chip select
// fsm, half period divider, sclk for cpol/cpha, mosi and miso shifters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_master #(
	parameter logic        CPOL    = 1'b1,			// sclk idle level
	parameter logic        CPHA    = 1'b1,			// 1 = sample on trailing edge
	parameter logic [15:0] CLK_DIV = 16'd3			// sys_clk cycles per half period, minus one
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               xfer_start,		// one-cycle start strobe
	input  spi_pkg::spi_xfer_t xfer,			// byte and owner, valid with start
	output logic               xfer_done,		// one-cycle end strobe
	output spi_pkg::spi_rsp_t  rsp,				// valid with xfer_done
	output logic               busy,
	output logic               cs,
	output logic               sclk,
	output logic               mosi,
	input  logic               miso
);

	spi_pkg::spi_state_e state;
	spi_pkg::spi_owner_e owner_q;				// owner latched at start
	logic [15:0]         cnt_clk;				// half period counter
	logic [3:0]          cnt_edge;				// sclk edges seen, 0..15
	logic [7:0]          tx_shift;
	logic [7:0]          rx_shift;
	logic                half_end;
	logic                last_end;
	logic                shift_en;
	logic                sample_en;

	assign half_end  = (cnt_clk == CLK_DIV - 16'd1);	// edge cycle takes the last count
	assign last_end  = (cnt_clk == CLK_DIV);
	// cpha=1 keeps bit 7 through the first pair of edges
	assign shift_en  = CPHA ? (~cnt_edge[0] && cnt_edge != 4'd0) : cnt_edge[0];
	assign sample_en = CPHA ? cnt_edge[0] : ~cnt_edge[0];

	assign busy      = (state != spi_pkg::ST_IDLE);
	assign mosi      = tx_shift[7];				// msb first
	assign rsp.owner = owner_q;
	assign rsp.data  = rx_shift;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= spi_pkg::ST_IDLE;
		end else begin
			case (state)
				spi_pkg::ST_IDLE: begin
					if (xfer_start && CLK_DIV == 16'd0)
						state <= spi_pkg::ST_EDGE;		// no wait cycles at div 0
					else if (xfer_start)
						state <= spi_pkg::ST_HALF;
				end
				spi_pkg::ST_HALF: begin
					if (half_end)
						state <= spi_pkg::ST_EDGE;
				end
				spi_pkg::ST_EDGE: begin
					if (cnt_edge == 4'd15)
						state <= spi_pkg::ST_LAST;
					else if (CLK_DIV != 16'd0)
						state <= spi_pkg::ST_HALF;
				end
				spi_pkg::ST_LAST: begin
					if (last_end)
						state <= spi_pkg::ST_DONE;
				end
				default: state <= spi_pkg::ST_IDLE;	// done back to idle
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= 16'd0;
		else if ((state == spi_pkg::ST_HALF && !half_end) ||
				(state == spi_pkg::ST_LAST && !last_end))
			cnt_clk <= cnt_clk + 16'd1;
		else
			cnt_clk <= 16'd0;						// restart each half period
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt_edge  <= 4'd0;
			sclk      <= CPOL;
			cs        <= 1'b1;
			xfer_done <= 1'b0;
			tx_shift  <= 8'd0;
		end else begin
			xfer_done <= (state == spi_pkg::ST_LAST) && last_end;
			if (state == spi_pkg::ST_IDLE) begin
				cnt_edge <= 4'd0;
				sclk     <= CPOL;
			end else if (state == spi_pkg::ST_EDGE) begin
				cnt_edge <= cnt_edge + 4'd1;		// wraps to 0 after edge 15
				sclk     <= ~sclk;
			end
			if (state == spi_pkg::ST_IDLE && xfer_start)
				cs <= 1'b0;
			else if (state == spi_pkg::ST_LAST && last_end)
				cs <= 1'b1;						// rises with xfer_done
			if (state == spi_pkg::ST_IDLE && xfer_start)
				tx_shift <= xfer.data;
			else if (state == spi_pkg::ST_EDGE && shift_en)
				tx_shift <= {tx_shift[6:0], 1'b0};
			else if (state == spi_pkg::ST_DONE)
				tx_shift <= 8'd0;					// park mosi low
		end
	end

	// receive byte and owner tag
	always_ff @(posedge sys_clk) begin
		if (state == spi_pkg::ST_IDLE && xfer_start) begin
			rx_shift <= 8'd0;
			owner_q  <= xfer.owner;
		end else if (state == spi_pkg::ST_EDGE && sample_en) begin
			rx_shift <= {rx_shift[6:0], miso};
		end
	end

endmodule

// ==== verilog/spi_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi_arbiter: one pending slot per client, host has priority
// response routing by owner tag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_arbiter (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               host_req,
	input  spi_pkg::spi_xfer_t host_data,
	output logic               host_done,
	output logic [7:0]         host_rx,
	input  logic               poll_req,
	input  spi_pkg::spi_xfer_t poll_xfer,
	output logic               poll_done,
	output logic [7:0]         poll_rx,
	output logic               xfer_start,
	output spi_pkg::spi_xfer_t xfer,
	input  logic               busy,
	input  logic               xfer_done,
	input  spi_pkg::spi_rsp_t  rsp
);

	spi_pkg::spi_xfer_t host_q;			// held host request
	spi_pkg::spi_xfer_t poll_q;			// held poll request
	spi_pkg::spi_rsp_t  rsp_q;			// registered response
	logic               host_pend;
	logic               poll_pend;
	logic               inflight;		// granted, engine not yet done
	logic               done_q;
	logic               grant;

	assign grant     = !busy && !inflight && (host_pend || poll_pend);
	assign host_done = done_q && (rsp_q.owner == spi_pkg::OWN_HOST);
	assign poll_done = done_q && (rsp_q.owner == spi_pkg::OWN_POLL);
	assign host_rx   = rsp_q.data;
	assign poll_rx   = rsp_q.data;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			host_pend  <= 1'b0;
			poll_pend  <= 1'b0;
			inflight   <= 1'b0;
			xfer_start <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			if (host_req && !host_pend)
				host_pend <= 1'b1;				// repeat strobes dropped while pending
			else if (xfer_done && rsp.owner == spi_pkg::OWN_HOST)
				host_pend <= 1'b0;
			if (poll_req && !poll_pend)
				poll_pend <= 1'b1;
			else if (xfer_done && rsp.owner == spi_pkg::OWN_POLL)
				poll_pend <= 1'b0;
			if (grant)
				inflight <= 1'b1;
			else if (xfer_done)
				inflight <= 1'b0;
			xfer_start <= grant;
			done_q     <= xfer_done;
		end
	end

	// payload, no reset
	always_ff @(posedge sys_clk) begin
		if (host_req && !host_pend)
			host_q <= host_data;
		if (poll_req && !poll_pend)
			poll_q <= poll_xfer;
		if (grant)
			xfer <= host_pend ? host_q : poll_q;	// host first
		if (xfer_done)
			rsp_q <= rsp;
	end

endmodule

// ==== verilog/spi_poller.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi_poller: periodic status read
// period counter, fixed command request, status byte latch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_poller #(
	parameter logic [15:0] POLL_PERIOD = 16'd400,		// cycles from done to next request
	parameter logic [7:0]  POLL_CMD    = 8'h3c			// command byte sent each poll
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	output logic               poll_req,
	output spi_pkg::spi_xfer_t poll_xfer,
	input  logic               poll_done,
	input  logic [7:0]         poll_rx,
	output logic [7:0]         status,
	output logic               status_valid
);

	logic [15:0] cnt_period;
	logic        wait_rsp;					// request out, no response yet
	logic        hit;

	assign hit             = (cnt_period == POLL_PERIOD);
	assign poll_xfer.owner = spi_pkg::OWN_POLL;
	assign poll_xfer.data  = POLL_CMD;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt_period   <= 16'd0;
			wait_rsp     <= 1'b0;
			poll_req     <= 1'b0;
			status       <= 8'd0;
			status_valid <= 1'b0;
		end else begin
			poll_req     <= hit && !wait_rsp;	// one strobe per period
			status_valid <= poll_done;
			if (poll_done) begin
				cnt_period <= 16'd0;			// next period starts here
				wait_rsp   <= 1'b0;
				status     <= poll_rx;
			end else if (hit) begin
				wait_rsp   <= 1'b1;			// hold count until done
			end else if (!wait_rsp) begin
				cnt_period <= cnt_period + 16'd1;
			end
		end
	end

endmodule

// ==== verilog/spi_subsys.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi_subsys: top level of the spi master subsystem
// poller, arbiter and engine with their parameters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_subsys #(
	parameter logic        CPOL        = 1'b1,
	parameter logic        CPHA        = 1'b1,
	parameter logic [15:0] CLK_DIV     = 16'd3,
	parameter logic [15:0] POLL_PERIOD = 16'd400,
	parameter logic [7:0]  POLL_CMD    = 8'h3c
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       host_req,		// one-cycle strobe
	input  logic [7:0] host_data,
	output logic       host_done,
	output logic [7:0] host_rx,
	output logic [7:0] status,			// last polled byte
	output logic       status_valid,
	output logic       cs,
	output logic       sclk,
	output logic       mosi,
	input  logic       miso
);

	spi_pkg::spi_xfer_t host_xfer;		// host byte with owner tag
	spi_pkg::spi_xfer_t poll_xfer;
	spi_pkg::spi_xfer_t xfer;
	spi_pkg::spi_rsp_t  rsp;
	logic               poll_req;
	logic               poll_done;
	logic [7:0]         poll_rx;
	logic               xfer_start;
	logic               xfer_done;
	logic               busy;

	assign host_xfer.owner = spi_pkg::OWN_HOST;
	assign host_xfer.data  = host_data;

	spi_poller #(
		.POLL_PERIOD (POLL_PERIOD),
		.POLL_CMD    (POLL_CMD)
	) poller0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.poll_req     (poll_req),
		.poll_xfer    (poll_xfer),
		.poll_done    (poll_done),
		.poll_rx      (poll_rx),
		.status       (status),
		.status_valid (status_valid)
	);

	spi_arbiter arb0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.host_req   (host_req),
		.host_data  (host_xfer),
		.host_done  (host_done),
		.host_rx    (host_rx),
		.poll_req   (poll_req),
		.poll_xfer  (poll_xfer),
		.poll_done  (poll_done),
		.poll_rx    (poll_rx),
		.xfer_start (xfer_start),
		.xfer       (xfer),
		.busy       (busy),
		.xfer_done  (xfer_done),
		.rsp        (rsp)
	);

	spi_master #(
		.CPOL    (CPOL),
		.CPHA    (CPHA),
		.CLK_DIV (CLK_DIV)
	) master0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.xfer_start (xfer_start),
		.xfer       (xfer),
		.xfer_done  (xfer_done),
		.rsp        (rsp),
		.busy       (busy),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso)
	);

endmodule

// ==== bench/spi_dev_model.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral spi device for the testbench
// reply register out on miso, mosi capture, reply update at cs rise
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_dev_model #(
	parameter logic CPOL = 1'b1,				// sclk idle level
	parameter logic CPHA = 1'b1					// 1 = sample on trailing edge
) (
	input  logic       cs,
	input  logic       sclk,
	input  logic       mosi,
	output logic       miso,
	output logic [7:0] rx_byte				// last complete byte from mosi
);

	logic       sample_lvl;
	logic       cs_q     = 1'b1;			// cs level at the previous event
	logic       miso_q   = 1'b0;
	logic [7:0] reply    = 8'ha5;			// reply register after reset
	logic [7:0] tx_shift = 8'h00;
	logic [7:0] rx_shift = 8'h00;
	logic [7:0] rx_last  = 8'h00;
	logic [3:0] nbits    = 4'd0;			// bits sampled in this frame

	assign sample_lvl = ~(CPOL ^ CPHA);		// sclk level right after a sample edge
	assign miso       = miso_q;
	assign rx_byte    = rx_last;

	// cs and both sclk edges in one process, cs_q tells them apart
	always @(posedge cs or negedge cs or posedge sclk or negedge sclk) begin
		cs_q <= cs;
		if (!cs && cs_q) begin
			tx_shift <= reply;				// frame start
			miso_q   <= reply[7];			// msb on the line before any edge
			rx_shift <= 8'h00;
			nbits    <= 4'd0;
		end else if (cs && !cs_q) begin
			rx_last <= rx_shift;
			reply   <= rx_shift ^ 8'h5a;	// next reply from this byte
		end else if (!cs && sclk == sample_lvl) begin
			rx_shift <= {rx_shift[6:0], mosi};	// msb first
			nbits    <= nbits + 4'd1;
		end else if (!cs && nbits != 4'd0) begin
			tx_shift <= {tx_shift[6:0], 1'b0};	// no shift before the first sample
			miso_q   <= tx_shift[6];
		end
	end

endmodule

// ==== bench/tb_spi_subsys.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spi subsystem in mode 3
// clock, reset, watchdog, device model, directed tests and summary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_spi_subsys;

	localparam logic        CPOL        = 1'b1;
	localparam logic        CPHA        = 1'b1;
	localparam logic [15:0] CLK_DIV     = 16'd3;
	localparam logic [15:0] POLL_PERIOD = 16'd400;
	localparam logic [7:0]  POLL_CMD    = 8'h3c;
	localparam logic [7:0]  REPLY_XOR   = 8'h5a;		// device reply rule
	localparam int          CLK_PERIOD  = 8;
	// 16 edges plus tail half period, plus arbiter and start cycles
	localparam int XFER_CYCLES = 17 * (int'(CLK_DIV) + 1) + 6;
	localparam int POLL_CYCLES = int'(POLL_PERIOD) + 4;
	// reset, idle window, 9 transfers worst case, 2 poll periods, slack
	localparam int RUN_CYCLES  = 23 + 9 * XFER_CYCLES + 2 * POLL_CYCLES + 240;

	logic       sys_clk = 1'b0;
	logic       sys_rst_n;
	logic       host_req;
	logic [7:0] host_data;
	logic       host_done;
	logic [7:0] host_rx;
	logic [7:0] status;
	logic       status_valid;
	logic       cs;
	logic       sclk;
	logic       mosi;
	logic       miso;
	logic [7:0] dev_rx;						// model's last received byte
	logic [7:0] exp_reply     = 8'ha5;		// predicted device reply register
	int         errs          = 0;
	int         pass_cnt      = 0;
	int         fail_cnt      = 0;
	int         host_done_cnt = 0;
	int         valid_cnt     = 0;

	spi_subsys #(
		.CPOL        (CPOL),
		.CPHA        (CPHA),
		.CLK_DIV     (CLK_DIV),
		.POLL_PERIOD (POLL_PERIOD),
		.POLL_CMD    (POLL_CMD)
	) dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.host_req     (host_req),
		.host_data    (host_data),
		.host_done    (host_done),
		.host_rx      (host_rx),
		.status       (status),
		.status_valid (status_valid),
		.cs           (cs),
		.sclk         (sclk),
		.mosi         (mosi),
		.miso         (miso)
	);

	spi_dev_model #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) dev0 (
		.cs      (cs),
		.sclk    (sclk),
		.mosi    (mosi),
		.miso    (miso),
		.rx_byte (dev_rx)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// strobe counters, one count per pulse
	always @(posedge sys_clk) begin
		if (host_done)
			host_done_cnt++;
		if (status_valid)
			valid_cnt++;
	end

	task automatic step();
		@(posedge sys_clk);
		#1;										// drive and sample point
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] exp_val,
			input logic [7:0] got);
		$display("ERR %s expected %h got %h at %0t", name, exp_val, got, $time);
		errs++;
	endtask

	task automatic report_fail(input string msg);
		$display("error: %s at %0t", msg, $time);
		errs++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errs == errs_before) begin
			pass_cnt++;
			$display("[ok]   %s", name);
		end else begin
			fail_cnt++;
			$display("[FAIL] %s, %0d errors", name, errs - errs_before);
		end
	endtask

	task automatic pulse_host_req(input logic [7:0] data);
		host_req  = 1'b1;
		host_data = data;
		step();
		host_req  = 1'b0;
	endtask

	task automatic wait_host_done(output logic ok);
		int n;
		n = 0;
		while (host_done !== 1'b1 && n < 2 * XFER_CYCLES) begin
			step();
			n++;
		end
		ok = (host_done === 1'b1);
		if (!ok)
			report_fail("no host_done arrived after host_req");
	endtask

	task automatic wait_status_valid(output logic ok);
		int n;
		n = 0;
		while (status_valid !== 1'b1 && n < POLL_CYCLES + 2 * XFER_CYCLES) begin
			step();
			n++;
		end
		ok = (status_valid === 1'b1);
		if (!ok)
			report_fail("no status_valid arrived within a poll period");
	endtask

	// one host byte, checked against the device rule
	task automatic host_xfer_check(input logic [7:0] tx);
		logic ok;
		pulse_host_req(tx);
		wait_host_done(ok);
		if (ok && host_rx !== exp_reply)
			report_mismatch("host_rx", exp_reply, host_rx);
		if (ok && dev_rx !== tx)
			report_mismatch("dev_rx", tx, dev_rx);
		exp_reply = tx ^ REPLY_XOR;
	endtask

	task automatic test_reset();
		int e0;
		e0 = errs;
		if (cs !== 1'b1)
			report_mismatch("cs", 8'h01, 8'(cs));
		if (sclk !== CPOL)
			report_mismatch("sclk", 8'(CPOL), 8'(sclk));
		if (mosi !== 1'b0)
			report_mismatch("mosi", 8'h00, 8'(mosi));
		if (status !== 8'h00)
			report_mismatch("status", 8'h00, status);
		repeat (20)
			step();
		if (host_done_cnt != 0 || valid_cnt != 0)
			report_fail("done or valid strobe seen in the idle window after reset");
		if (cs !== 1'b1)
			report_mismatch("cs", 8'h01, 8'(cs));
		finish_test("reset state", e0);
	endtask

	task automatic test_single();
		int e0;
		e0 = errs;
		host_xfer_check(8'($urandom()));
		finish_test("single host transfer", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = errs;
		repeat (3) begin
			host_xfer_check(8'($urandom()));
			if (cs !== 1'b1)
				report_mismatch("cs", 8'h01, 8'(cs));	// high between frames
		end
		finish_test("back-to-back host transfers", e0);
	endtask

	task automatic test_poll();
		int   e0;
		logic ok;
		e0 = errs;
		wait_status_valid(ok);
		if (ok && status !== exp_reply)
			report_mismatch("status", exp_reply, status);
		if (ok && dev_rx !== POLL_CMD)
			report_mismatch("dev_rx", POLL_CMD, dev_rx);
		exp_reply = POLL_CMD ^ REPLY_XOR;
		finish_test("poll cycle", e0);
	endtask

	task automatic test_contention();
		int         e0;
		int         v0;
		int         n;
		logic       ok;
		logic [7:0] tx;
		e0 = errs;
		tx = 8'($urandom());
		// host strobe lands on the same edge as the poll request
		n = 0;
		while (dut0.poll_req !== 1'b1 && n < POLL_CYCLES + XFER_CYCLES) begin
			step();
			n++;
		end
		if (dut0.poll_req !== 1'b1)
			report_fail("poll request did not come due within a poll period");
		v0 = valid_cnt;
		host_xfer_check(tx);
		if (valid_cnt != v0)
			report_fail("poll response came before the host response");
		wait_status_valid(ok);
		if (ok && status !== exp_reply)
			report_mismatch("status", exp_reply, status);
		if (ok && dev_rx !== POLL_CMD)
			report_mismatch("dev_rx", POLL_CMD, dev_rx);
		exp_reply = POLL_CMD ^ REPLY_XOR;
		finish_test("host and poll contention", e0);
	endtask

	task automatic test_duplicate();
		int         e0;
		int         d0;
		logic       ok;
		logic [7:0] tx;
		e0 = errs;
		d0 = host_done_cnt;
		tx = 8'($urandom());
		pulse_host_req(tx);
		repeat (10)
			step();
		pulse_host_req(~tx);					// still pending, must be dropped
		wait_host_done(ok);
		if (ok && host_rx !== exp_reply)
			report_mismatch("host_rx", exp_reply, host_rx);
		repeat (XFER_CYCLES + 20)
			step();
		if (host_done_cnt - d0 != 1)
			report_fail($sformatf("expected one host_done, saw %0d", host_done_cnt - d0));
		if (dev_rx !== tx)
			report_mismatch("dev_rx", tx, dev_rx);
		exp_reply = tx ^ REPLY_XOR;
		finish_test("duplicate host request", e0);
	endtask

	initial begin
		void'($urandom(32'h7e98));
		sys_rst_n = 1'b0;
		host_req  = 1'b0;
		host_data = 8'h00;
		repeat (3)
			@(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		test_reset();
		test_single();
		test_back_to_back();
		test_poll();
		test_contention();
		test_duplicate();
		$display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", RUN_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/spi_pkg.sv
verilog/spi_master.sv
verilog/spi_arbiter.sv
verilog/spi_poller.sv
verilog/spi_subsys.sv
bench/spi_dev_model.sv
bench/tb_spi_subsys.sv

// ==== Makefile ====
TB_TOP  = tb_spi_subsys
RTL_TOP = spi_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timescale 1ns/1ns --top-module $(RTL_TOP) \
		verilog/spi_pkg.sv verilog/spi_master.sv verilog/spi_arbiter.sv \
		verilog/spi_poller.sv verilog/spi_subsys.sv

sim:
	verilator --binary --timing --timescale 1ns/1ns -f flist.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
